// File: list.f
+incdir+hw
hw/tile_mem_pkg.sv
hw/tile_dev_pkg.sv
hw/tile_mem_router.sv
hw/tile_cfg_regs.sv
hw/tile_clint.sv
hw/tile_mem_top.sv
tb/tile_mem_chk.sv
tb/tile_mem_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the tile memory map testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tile_mem_tb \
  -Mdir "$BUILD_DIR" -o tile_mem_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tile_mem_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F "Test failed" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi

echo "No failure reported in $LOG"
exit 0

// File: tb/tile_mem_tb.sv
// ********************
// Tile memory map testbench
// Table driven commands with an off-tile memory model
// ********************

`timescale 1ns/1ps
`include "tile_settings.svh"

module tile_mem_tb;

  import tile_mem_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int NUM_TESTS   = 21;
  localparam int RESP_WAIT   = 150;
  localparam int NONE_WAIT   = 20;
  localparam int SIG_WAIT    = 100;
  localparam int HOLD_CYCLES = 20;

  // Where the response is expected from
  localparam int SRC_MEM   = 0;
  localparam int SRC_LOCAL = 1;
  localparam int SRC_NONE  = 2;

  // Output checked once the response is taken
  localparam int SIG_NONE   = 0;
  localparam int SIG_FREEZE = 1;
  localparam int SIG_SWI    = 2;
  localparam int SIG_TIMER  = 3;

  // Config is device 2 and interrupt slice device 1 in the field at bit 20
  localparam logic [`TILE_PADDR_WIDTH-1:0] CFG_BASE   = 40'h00_0020_0000;
  localparam logic [`TILE_PADDR_WIDTH-1:0] CLINT_BASE = 40'h00_0010_0000;
  localparam logic [`TILE_DATA_WIDTH-1:0]  MEM_XOR    = 64'hA5A5_0000_5A5A_0000;
  localparam logic [`TILE_DATA_WIDTH-1:0]  ALL_ONES   = 64'hFFFF_FFFF_FFFF_FFFF;

  logic                         clk_i = 1'b0;
  logic                         rst_n_i;
  logic                         cmd_v_i;
  mem_opcode_e                  cmd_opcode_i;
  logic [`TILE_PADDR_WIDTH-1:0] cmd_addr_i;
  logic [`TILE_DATA_WIDTH-1:0]  cmd_data_i;
  logic                         cmd_ready_o;
  logic                         resp_v_o;
  mem_opcode_e                  resp_opcode_o;
  logic [`TILE_PADDR_WIDTH-1:0] resp_addr_o;
  logic [`TILE_DATA_WIDTH-1:0]  resp_data_o;
  logic                         resp_yumi_i;
  logic                         mem_cmd_v_o;
  mem_opcode_e                  mem_cmd_opcode_o;
  logic [`TILE_PADDR_WIDTH-1:0] mem_cmd_addr_o;
  logic [`TILE_DATA_WIDTH-1:0]  mem_cmd_data_o;
  logic                         mem_cmd_ready_i = 1'b0;
  logic                         mem_resp_v_i = 1'b0;
  mem_opcode_e                  mem_resp_opcode_i = e_mem_load;
  logic [`TILE_PADDR_WIDTH-1:0] mem_resp_addr_i = '0;
  logic [`TILE_DATA_WIDTH-1:0]  mem_resp_data_i = '0;
  logic                         mem_resp_yumi_o;
  logic [`TILE_DID_WIDTH-1:0]   host_did_i;
  logic [`TILE_DID_WIDTH-1:0]   my_did_i;
  logic                         freeze_o;
  logic                         timer_irq_o;
  logic                         software_irq_o;

  // Stimulus table
  string                        t_name  [NUM_TESTS];
  mem_opcode_e                  t_op    [NUM_TESTS];
  logic [`TILE_PADDR_WIDTH-1:0] t_addr  [NUM_TESTS];
  logic [`TILE_DATA_WIDTH-1:0]  t_data  [NUM_TESTS];
  logic [`TILE_DATA_WIDTH-1:0]  t_exp   [NUM_TESTS];
  int                           t_src   [NUM_TESTS];
  int                           t_sig   [NUM_TESTS];
  logic                         t_level [NUM_TESTS];
  logic                         t_hold  [NUM_TESTS];
  logic                         t_incr  [NUM_TESTS];
  int                           n_tests = 0;

  integer                       seed = 32'h089bde39;
  logic                         yumi_coin = 1'b0;
  int                           passes = 0;
  int                           failures = 0;
  logic [`TILE_DATA_WIDTH-1:0]  last_mtime = '0;

  // Off-tile memory model state
  logic [`TILE_PADDR_WIDTH-1:0] pend_addr [$];
  mem_opcode_e                  pend_op [$];
  int                           delay_cnt = 0;
  int                           mem_accepts = 0;
  logic [`TILE_DATA_WIDTH-1:0]  mem_last_data = '0;

  tile_mem_top UUT (.*);

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // Random stalls and latency with responses held until the yumi
  always @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      mem_cmd_ready_i <= 1'b0;
      mem_resp_v_i    <= 1'b0;
      delay_cnt       <= 0;
    end
    else
    begin
      mem_cmd_ready_i <= (($random(seed) & 3) != 0);
      yumi_coin       <= (($random(seed) & 1) != 0);
      if (mem_resp_v_i)
      begin
        if (mem_resp_yumi_o)
        begin
          mem_resp_v_i <= 1'b0;
          void'(pend_addr.pop_front());
          void'(pend_op.pop_front());
          delay_cnt <= $unsigned($random(seed)) % 8;
        end
      end
      else if (pend_addr.size() != 0)
      begin
        if (delay_cnt != 0)
          delay_cnt <= delay_cnt - 1;
        else
        begin
          mem_resp_v_i      <= 1'b1;
          mem_resp_opcode_i <= pend_op[0];
          mem_resp_addr_i   <= pend_addr[0];
          mem_resp_data_i   <= (pend_op[0] == e_mem_load) ?
                               (64'(pend_addr[0]) ^ MEM_XOR) : '0;
        end
      end
      if (mem_cmd_v_o && mem_cmd_ready_i)
      begin
        pend_addr.push_back(mem_cmd_addr_o);
        pend_op.push_back(mem_cmd_opcode_o);
        mem_last_data <= mem_cmd_data_o;
        mem_accepts   <= mem_accepts + 1;
      end
    end
  end

  task automatic add_test(input string name, input mem_opcode_e op,
                          input logic [`TILE_PADDR_WIDTH-1:0] addr,
                          input logic [`TILE_DATA_WIDTH-1:0] data,
                          input logic [`TILE_DATA_WIDTH-1:0] exp, input int src);
    t_name[n_tests]  = name;
    t_op[n_tests]    = op;
    t_addr[n_tests]  = addr;
    t_data[n_tests]  = data;
    t_exp[n_tests]   = exp;
    t_src[n_tests]   = src;
    t_sig[n_tests]   = SIG_NONE;
    t_level[n_tests] = 1'b0;
    t_hold[n_tests]  = 1'b0;
    t_incr[n_tests]  = 1'b0;
    n_tests++;
  endtask

  task automatic expect_level(input int sig, input logic level);
    t_sig[n_tests-1]   = sig;
    t_level[n_tests-1] = level;
  endtask

  task automatic build_table();
    add_test("cfg_freeze_reset", e_mem_load, CFG_BASE, '0, 64'h1, SRC_LOCAL);
    expect_level(SIG_FREEZE, 1'b1);
    add_test("cfg_freeze_clear", e_mem_store, CFG_BASE, '0, '0, SRC_LOCAL);
    expect_level(SIG_FREEZE, 1'b0);
    add_test("cfg_freeze_load", e_mem_load, CFG_BASE, '0, '0, SRC_LOCAL);
    add_test("cfg_host_did", e_mem_load, CFG_BASE + 40'h08, '0, 64'd5, SRC_LOCAL);
    add_test("cfg_my_did", e_mem_load, CFG_BASE + 40'h10, '0, 64'd2, SRC_LOCAL);
    add_test("cfg_unmapped", e_mem_load, CFG_BASE + 40'h18, '0, '0, SRC_LOCAL);
    add_test("offtile_load_lo", e_mem_load, 40'h00_8000_0000, '0,
             64'hA5A5_0000_DA5A_0000, SRC_MEM);
    add_test("offtile_load_hi", e_mem_load, 40'hFF_FFFF_FFF8, '0,
             64'hA5A5_00FF_A5A5_FFF8, SRC_MEM);
    add_test("offtile_store", e_mem_store, 40'h12_3456_7800, 64'h1234, '0, SRC_MEM);
    add_test("clint_cmp_reset", e_mem_load, CLINT_BASE + 40'h08, '0, ALL_ONES, SRC_LOCAL);
    expect_level(SIG_TIMER, 1'b0);
    add_test("clint_msip_set", e_mem_store, CLINT_BASE, 64'h1, '0, SRC_LOCAL);
    expect_level(SIG_SWI, 1'b1);
    add_test("clint_msip_load", e_mem_load, CLINT_BASE, '0, 64'h1, SRC_LOCAL);
    add_test("clint_msip_clear", e_mem_store, CLINT_BASE, '0, '0, SRC_LOCAL);
    expect_level(SIG_SWI, 1'b0);
    add_test("clint_mtime_a", e_mem_load, CLINT_BASE + 40'h10, '0, '0, SRC_LOCAL);
    t_incr[n_tests-1] = 1'b1;
    add_test("clint_mtime_b", e_mem_load, CLINT_BASE + 40'h10, '0, '0, SRC_LOCAL);
    t_incr[n_tests-1] = 1'b1;
    add_test("clint_cmp_set", e_mem_store, CLINT_BASE + 40'h08, 64'd50, '0, SRC_LOCAL);
    expect_level(SIG_TIMER, 1'b1);
    add_test("clint_cmp_clear", e_mem_store, CLINT_BASE + 40'h08, ALL_ONES, '0, SRC_LOCAL);
    expect_level(SIG_TIMER, 1'b0);
    add_test("cfg_backpressure", e_mem_load, CFG_BASE + 40'h08, '0, 64'd5, SRC_LOCAL);
    t_hold[n_tests-1] = 1'b1;
    add_test("clint_backpressure", e_mem_load, CLINT_BASE + 40'h08, '0, ALL_ONES, SRC_LOCAL);
    t_hold[n_tests-1] = 1'b1;
    add_test("dev_unmapped", e_mem_load, 40'h00_0030_0000, '0, '0, SRC_NONE);
    add_test("offtile_after_bp", e_mem_load, 40'h80_0000_1000, '0,
             64'hA5A5_0080_5A5A_1000, SRC_MEM);
  endtask

  task automatic issue_cmd(input int i);
    @(posedge clk_i);
    cmd_v_i      <= 1'b1;
    cmd_opcode_i <= t_op[i];
    cmd_addr_i   <= t_addr[i];
    cmd_data_i   <= t_data[i];
    do
      @(negedge clk_i);
    while (!cmd_ready_o);
    @(posedge clk_i);
    cmd_v_i <= 1'b0;
  endtask

  task automatic take_resp(input int i, input int limit, output logic got,
                           output mem_opcode_e op,
                           output logic [`TILE_PADDR_WIDTH-1:0] addr,
                           output logic [`TILE_DATA_WIDTH-1:0] data, inout logic ok);
    int                          waited;
    logic                        broken;
    logic [`TILE_DATA_WIDTH-1:0] held;
    waited = 0;
    broken = 1'b0;
    got    = 1'b0;
    op     = e_mem_load;
    addr   = '0;
    data   = '0;
    do
    begin
      @(negedge clk_i);
      waited++;
    end
    while (!resp_v_o && waited < limit);
    if (resp_v_o)
    begin
      if (t_hold[i])
      begin
        held = resp_data_o;
        repeat (HOLD_CYCLES)
        begin
          @(negedge clk_i);
          if (!resp_v_o || resp_data_o !== held || cmd_ready_o)
            broken = 1'b1;
        end
        if (broken)
        begin
          $display("%s: response dropped or changed, or commands accepted while stalled",
                   t_name[i]);
          ok = 1'b0;
        end
      end
      do
      begin
        @(posedge clk_i);
        resp_yumi_i <= yumi_coin;
        @(negedge clk_i);
      end
      while (!resp_yumi_i);
      got  = 1'b1;
      op   = resp_opcode_o;
      addr = resp_addr_o;
      data = resp_data_o;
      @(posedge clk_i);
      resp_yumi_i <= 1'b0;
    end
  endtask

  function automatic logic sample_level(input int sig);
    case (sig)
      SIG_FREEZE: return freeze_o;
      SIG_SWI:    return software_irq_o;
      default:    return timer_irq_o;
    endcase
  endfunction

  task automatic check_level(input int i, inout logic ok);
    int   waited;
    int   limit;
    logic level;
    waited = 0;
    // Only the timer rise is allowed to take a while
    limit = (t_sig[i] == SIG_TIMER && t_level[i]) ? SIG_WAIT : 1;
    do
    begin
      @(negedge clk_i);
      level = sample_level(t_sig[i]);
      waited++;
    end
    while (level !== t_level[i] && waited < limit);
    if (level !== t_level[i])
    begin
      $display("mismatch %s: expected level %b actual %b", t_name[i], t_level[i], level);
      ok = 1'b0;
    end
  endtask

  task automatic run_entry(input int i);
    int                           accepts_before;
    logic                         got;
    logic                         ok;
    mem_opcode_e                  op;
    logic [`TILE_PADDR_WIDTH-1:0] addr;
    logic [`TILE_DATA_WIDTH-1:0]  data;
    ok = 1'b1;
    accepts_before = mem_accepts;
    issue_cmd(i);
    take_resp(i, (t_src[i] == SRC_NONE) ? NONE_WAIT : RESP_WAIT, got, op, addr, data, ok);
    if (t_src[i] == SRC_NONE)
    begin
      if (got)
      begin
        $display("%s: got a response for a command that should be discarded", t_name[i]);
        ok = 1'b0;
      end
    end
    else if (!got)
    begin
      $display("%s: no response within %0d cycles", t_name[i], RESP_WAIT);
      ok = 1'b0;
    end
    else
    begin
      if (addr !== t_addr[i] || op !== t_op[i])
      begin
        $display("mismatch %s: expected addr %h op %0d actual addr %h op %0d",
                 t_name[i], t_addr[i], t_op[i], addr, op);
        ok = 1'b0;
      end
      if (t_incr[i])
      begin
        if (data <= last_mtime)
        begin
          $display("mismatch %s: expected above %h actual %h", t_name[i], last_mtime, data);
          ok = 1'b0;
        end
        last_mtime = data;
      end
      else if (data !== t_exp[i])
      begin
        $display("mismatch %s: expected %h actual %h", t_name[i], t_exp[i], data);
        ok = 1'b0;
      end
    end
    if ((mem_accepts - accepts_before) != ((t_src[i] == SRC_MEM) ? 1 : 0))
    begin
      $display("%s: wrong destination, off-tile port took %0d commands",
               t_name[i], mem_accepts - accepts_before);
      ok = 1'b0;
    end
    if (t_src[i] == SRC_MEM && mem_last_data !== t_data[i])
    begin
      $display("mismatch %s: expected off-tile data %h actual %h",
               t_name[i], t_data[i], mem_last_data);
      ok = 1'b0;
    end
    if (t_sig[i] != SIG_NONE)
      check_level(i, ok);
    $display("%s: %s", t_name[i], ok ? "ok" : "error");
    if (ok)
      passes++;
    else
      failures++;
  endtask

  initial
  begin
    repeat (NUM_TESTS * 200 + 10) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, a test never finished", NUM_TESTS * 200);
    $display("Test failed");
    $finish;
  end

  initial
  begin
    int i;
    rst_n_i      = 1'b0;
    cmd_v_i      = 1'b0;
    cmd_opcode_i = e_mem_load;
    cmd_addr_i   = '0;
    cmd_data_i   = '0;
    resp_yumi_i  = 1'b0;
    host_did_i   = 3'd5;
    my_did_i     = 3'd2;
    build_table();
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (i = 0; i < n_tests; i++)
      run_entry(i);
    $display("%0d tests run, %0d passed, %0d failed", n_tests, passes, failures);
    if (failures == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// File: tb/tile_mem_chk.sv
// ********************
// Tile memory map checker
// Handshake and interrupt assertions on the top level
// ********************

`timescale 1ns/1ps
`include "tile_settings.svh"

module tile_mem_chk
  (input logic                           clk_i
  ,input logic                           rst_n_i
  ,input logic                           cmd_v_i
  ,input tile_mem_pkg::mem_opcode_e      cmd_opcode_i
  ,input logic [`TILE_PADDR_WIDTH-1:0]   cmd_addr_i
  ,input logic                           cmd_ready_o
  ,input logic                           resp_v_o
  ,input logic [`TILE_PADDR_WIDTH-1:0]   resp_addr_o
  ,input logic [`TILE_DATA_WIDTH-1:0]    resp_data_o
  ,input logic                           resp_yumi_i
  ,input logic                           timer_irq_o
  );

  import tile_mem_pkg::*;
  import tile_dev_pkg::*;

  logic cmp_store;
  logic cmp_written;

  // Store to mtimecmp accepted at the top level
  assign cmp_store = cmd_v_i & cmd_ready_o & (cmd_opcode_i == e_mem_store)
                     & (cmd_addr_i < `TILE_LOCAL_LIMIT)
                     & (cmd_addr_i[`TILE_DEV_LSB +: `TILE_DEV_WIDTH] == e_dev_clint)
                     & (cmd_addr_i[`TILE_REG_WIDTH-1:0] == e_clint_mtimecmp);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      cmp_written <= 1'b0;
    else if (cmp_store)
      cmp_written <= 1'b1;
  end

  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_v_o && !resp_yumi_i |=> resp_v_o && $stable(resp_data_o) && $stable(resp_addr_o))
    else $error("response dropped or changed before it was taken");

  yumi_with_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_yumi_i |-> resp_v_o)
    else $error("yumi raised without a valid response");

  idle_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> !resp_v_o && !timer_irq_o)
    else $error("response or timer interrupt active during reset");

  timer_needs_cmp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    timer_irq_o |-> cmp_written)
    else $error("timer interrupt without a compare store");

endmodule

bind tile_mem_top tile_mem_chk chk
  (.clk_i(clk_i), .rst_n_i(rst_n_i), .cmd_v_i(cmd_v_i), .cmd_opcode_i(cmd_opcode_i)
  ,.cmd_addr_i(cmd_addr_i), .cmd_ready_o(cmd_ready_o), .resp_v_o(resp_v_o)
  ,.resp_addr_o(resp_addr_o), .resp_data_o(resp_data_o), .resp_yumi_i(resp_yumi_i)
  ,.timer_irq_o(timer_irq_o)
  );

// File: hw/tile_mem_top.sv
// ********************
// Tile local memory map
// Router with configuration and interrupt slices
// and an off-tile memory port
// ********************

`timescale 1ns/1ps
`include "tile_settings.svh"

module tile_mem_top
  (input  logic                           clk_i
  ,input  logic                           rst_n_i

  ,input  logic                           cmd_v_i
  ,input  tile_mem_pkg::mem_opcode_e      cmd_opcode_i
  ,input  logic [`TILE_PADDR_WIDTH-1:0]   cmd_addr_i
  ,input  logic [`TILE_DATA_WIDTH-1:0]    cmd_data_i
  ,output logic                           cmd_ready_o

  ,output logic                           resp_v_o
  ,output tile_mem_pkg::mem_opcode_e      resp_opcode_o
  ,output logic [`TILE_PADDR_WIDTH-1:0]   resp_addr_o
  ,output logic [`TILE_DATA_WIDTH-1:0]    resp_data_o
  ,input  logic                           resp_yumi_i

  ,output logic                           mem_cmd_v_o
  ,output tile_mem_pkg::mem_opcode_e      mem_cmd_opcode_o
  ,output logic [`TILE_PADDR_WIDTH-1:0]   mem_cmd_addr_o
  ,output logic [`TILE_DATA_WIDTH-1:0]    mem_cmd_data_o
  ,input  logic                           mem_cmd_ready_i

  ,input  logic                           mem_resp_v_i
  ,input  tile_mem_pkg::mem_opcode_e      mem_resp_opcode_i
  ,input  logic [`TILE_PADDR_WIDTH-1:0]   mem_resp_addr_i
  ,input  logic [`TILE_DATA_WIDTH-1:0]    mem_resp_data_i
  ,output logic                           mem_resp_yumi_o

  ,input  logic [`TILE_DID_WIDTH-1:0]     host_did_i
  ,input  logic [`TILE_DID_WIDTH-1:0]     my_did_i
  ,output logic                           freeze_o
  ,output logic                           timer_irq_o
  ,output logic                           software_irq_o
  );

  import tile_mem_pkg::*;

  // Configuration slice channels
  logic                         cfg_cmd_v, cfg_cmd_ready;
  mem_opcode_e                  cfg_cmd_opcode;
  logic [`TILE_PADDR_WIDTH-1:0] cfg_cmd_addr;
  logic [`TILE_DATA_WIDTH-1:0]  cfg_cmd_data;
  logic                         cfg_resp_v, cfg_resp_yumi;
  mem_opcode_e                  cfg_resp_opcode;
  logic [`TILE_PADDR_WIDTH-1:0] cfg_resp_addr;
  logic [`TILE_DATA_WIDTH-1:0]  cfg_resp_data;

  // Interrupt slice channels
  logic                         clint_cmd_v, clint_cmd_ready;
  mem_opcode_e                  clint_cmd_opcode;
  logic [`TILE_PADDR_WIDTH-1:0] clint_cmd_addr;
  logic [`TILE_DATA_WIDTH-1:0]  clint_cmd_data;
  logic                         clint_resp_v, clint_resp_yumi;
  mem_opcode_e                  clint_resp_opcode;
  logic [`TILE_PADDR_WIDTH-1:0] clint_resp_addr;
  logic [`TILE_DATA_WIDTH-1:0]  clint_resp_data;

  tile_mem_router router
    (.cmd_v_i(cmd_v_i), .cmd_opcode_i(cmd_opcode_i), .cmd_addr_i(cmd_addr_i)
    ,.cmd_data_i(cmd_data_i), .cmd_ready_o(cmd_ready_o)
    ,.mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_opcode_o(mem_cmd_opcode_o)
    ,.mem_cmd_addr_o(mem_cmd_addr_o), .mem_cmd_data_o(mem_cmd_data_o)
    ,.mem_cmd_ready_i(mem_cmd_ready_i)
    ,.mem_resp_v_i(mem_resp_v_i), .mem_resp_opcode_i(mem_resp_opcode_i)
    ,.mem_resp_addr_i(mem_resp_addr_i), .mem_resp_data_i(mem_resp_data_i)
    ,.mem_resp_yumi_o(mem_resp_yumi_o)
    ,.cfg_cmd_v_o(cfg_cmd_v), .cfg_cmd_opcode_o(cfg_cmd_opcode)
    ,.cfg_cmd_addr_o(cfg_cmd_addr), .cfg_cmd_data_o(cfg_cmd_data)
    ,.cfg_cmd_ready_i(cfg_cmd_ready)
    ,.cfg_resp_v_i(cfg_resp_v), .cfg_resp_opcode_i(cfg_resp_opcode)
    ,.cfg_resp_addr_i(cfg_resp_addr), .cfg_resp_data_i(cfg_resp_data)
    ,.cfg_resp_yumi_o(cfg_resp_yumi)
    ,.clint_cmd_v_o(clint_cmd_v), .clint_cmd_opcode_o(clint_cmd_opcode)
    ,.clint_cmd_addr_o(clint_cmd_addr), .clint_cmd_data_o(clint_cmd_data)
    ,.clint_cmd_ready_i(clint_cmd_ready)
    ,.clint_resp_v_i(clint_resp_v), .clint_resp_opcode_i(clint_resp_opcode)
    ,.clint_resp_addr_i(clint_resp_addr), .clint_resp_data_i(clint_resp_data)
    ,.clint_resp_yumi_o(clint_resp_yumi)
    ,.resp_v_o(resp_v_o), .resp_opcode_o(resp_opcode_o), .resp_addr_o(resp_addr_o)
    ,.resp_data_o(resp_data_o), .resp_yumi_i(resp_yumi_i)
    );

  tile_cfg_regs cfg
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
    ,.cmd_v_i(cfg_cmd_v), .cmd_opcode_i(cfg_cmd_opcode), .cmd_addr_i(cfg_cmd_addr)
    ,.cmd_data_i(cfg_cmd_data), .cmd_ready_o(cfg_cmd_ready)
    ,.resp_v_o(cfg_resp_v), .resp_opcode_o(cfg_resp_opcode), .resp_addr_o(cfg_resp_addr)
    ,.resp_data_o(cfg_resp_data), .resp_yumi_i(cfg_resp_yumi)
    ,.host_did_i(host_did_i), .my_did_i(my_did_i), .freeze_o(freeze_o)
    );

  tile_clint clint
    (.clk_i(clk_i), .rst_n_i(rst_n_i)
    ,.cmd_v_i(clint_cmd_v), .cmd_opcode_i(clint_cmd_opcode), .cmd_addr_i(clint_cmd_addr)
    ,.cmd_data_i(clint_cmd_data), .cmd_ready_o(clint_cmd_ready)
    ,.resp_v_o(clint_resp_v), .resp_opcode_o(clint_resp_opcode)
    ,.resp_addr_o(clint_resp_addr), .resp_data_o(clint_resp_data)
    ,.resp_yumi_i(clint_resp_yumi)
    ,.timer_irq_o(timer_irq_o), .software_irq_o(software_irq_o)
    );

endmodule

// File: hw/tile_clint.sv
// ********************
// Tile interrupt slice
// Timer, compare and software interrupt registers
// ********************

`timescale 1ns/1ps
`include "tile_settings.svh"

module tile_clint
  (input  logic                           clk_i
  ,input  logic                           rst_n_i

  ,input  logic                           cmd_v_i
  ,input  tile_mem_pkg::mem_opcode_e      cmd_opcode_i
  ,input  logic [`TILE_PADDR_WIDTH-1:0]   cmd_addr_i
  ,input  logic [`TILE_DATA_WIDTH-1:0]    cmd_data_i
  ,output logic                           cmd_ready_o

  ,output logic                           resp_v_o
  ,output tile_mem_pkg::mem_opcode_e      resp_opcode_o
  ,output logic [`TILE_PADDR_WIDTH-1:0]   resp_addr_o
  ,output logic [`TILE_DATA_WIDTH-1:0]    resp_data_o
  ,input  logic                           resp_yumi_i

  ,output logic                           timer_irq_o
  ,output logic                           software_irq_o
  );

  import tile_mem_pkg::*;
  import tile_dev_pkg::*;

  logic                         cmd_fire;
  logic                         store_fire;
  clint_reg_e                   reg_sel;
  logic [`TILE_DATA_WIDTH-1:0]  rd_data;
  logic [`TILE_DATA_WIDTH-1:0]  mtime_r;
  logic [`TILE_DATA_WIDTH-1:0]  mtimecmp_r;
  logic                         msip_r;
  logic                         timer_irq_r;
  logic                         resp_v_r;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign store_fire  = cmd_fire & (cmd_opcode_i == e_mem_store);
  assign reg_sel     = clint_reg_e'(cmd_addr_i[`TILE_REG_WIDTH-1:0]);

  always_comb
  begin
    case (reg_sel)
      e_clint_msip:     rd_data = `TILE_DATA_WIDTH'(msip_r);
      e_clint_mtimecmp: rd_data = mtimecmp_r;
      e_clint_mtime:    rd_data = mtime_r;
      default:          rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mtime_r     <= '0;
      mtimecmp_r  <= '1;
      msip_r      <= 1'b0;
      timer_irq_r <= 1'b0;
    end
    else
    begin
      // A store overrides the free running increment
      if (store_fire && (reg_sel == e_clint_mtime))
        mtime_r <= cmd_data_i;
      else
        mtime_r <= mtime_r + `TILE_DATA_WIDTH'(1);

      if (store_fire && (reg_sel == e_clint_mtimecmp))
        mtimecmp_r <= cmd_data_i;

      if (store_fire && (reg_sel == e_clint_msip))
        msip_r <= cmd_data_i[0];

      timer_irq_r <= (mtime_r >= mtimecmp_r);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_r <= 1'b0;
    else if (cmd_fire)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;
  end

  // Held until the router hands back the yumi
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_opcode_o <= cmd_opcode_i;
      resp_addr_o   <= cmd_addr_i;
      resp_data_o   <= (cmd_opcode_i == e_mem_store) ? '0 : rd_data;
    end
  end

  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = timer_irq_r;
  assign software_irq_o = msip_r;

endmodule

// File: hw/tile_cfg_regs.sv
// ********************
// Tile configuration slice
// Freeze bit and network identity readback
// ********************

`timescale 1ns/1ps
`include "tile_settings.svh"

module tile_cfg_regs
  (input  logic                           clk_i
  ,input  logic                           rst_n_i

  ,input  logic                           cmd_v_i
  ,input  tile_mem_pkg::mem_opcode_e      cmd_opcode_i
  ,input  logic [`TILE_PADDR_WIDTH-1:0]   cmd_addr_i
  ,input  logic [`TILE_DATA_WIDTH-1:0]    cmd_data_i
  ,output logic                           cmd_ready_o

  ,output logic                           resp_v_o
  ,output tile_mem_pkg::mem_opcode_e      resp_opcode_o
  ,output logic [`TILE_PADDR_WIDTH-1:0]   resp_addr_o
  ,output logic [`TILE_DATA_WIDTH-1:0]    resp_data_o
  ,input  logic                           resp_yumi_i

  ,input  logic [`TILE_DID_WIDTH-1:0]     host_did_i
  ,input  logic [`TILE_DID_WIDTH-1:0]     my_did_i
  ,output logic                           freeze_o
  );

  import tile_mem_pkg::*;
  import tile_dev_pkg::*;

  logic                         cmd_fire;
  logic                         store_fire;
  cfg_reg_e                     reg_sel;
  logic [`TILE_DATA_WIDTH-1:0]  rd_data;
  logic                         freeze_r;
  logic                         resp_v_r;

  assign cmd_ready_o = ~resp_v_r;
  assign cmd_fire    = cmd_v_i & cmd_ready_o;
  assign store_fire  = cmd_fire & (cmd_opcode_i == e_mem_store);
  assign reg_sel     = cfg_reg_e'(cmd_addr_i[`TILE_REG_WIDTH-1:0]);

  // Unmapped offsets read as zero
  always_comb
  begin
    case (reg_sel)
      e_cfg_freeze:   rd_data = `TILE_DATA_WIDTH'(freeze_r);
      e_cfg_host_did: rd_data = `TILE_DATA_WIDTH'(host_did_i);
      e_cfg_my_did:   rd_data = `TILE_DATA_WIDTH'(my_did_i);
      default:        rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      freeze_r <= 1'b1;
      resp_v_r <= 1'b0;
    end
    else
    begin
      if (store_fire && (reg_sel == e_cfg_freeze))
        freeze_r <= cmd_data_i[0];
      if (cmd_fire)
        resp_v_r <= 1'b1;
      else if (resp_yumi_i)
        resp_v_r <= 1'b0;
    end
  end

  // One-entry response buffer
  always_ff @(posedge clk_i)
  begin
    if (cmd_fire)
    begin
      resp_opcode_o <= cmd_opcode_i;
      resp_addr_o   <= cmd_addr_i;
      resp_data_o   <= (cmd_opcode_i == e_mem_store) ? '0 : rd_data;
    end
  end

  assign resp_v_o = resp_v_r;
  assign freeze_o = freeze_r;

endmodule

// File: hw/tile_mem_router.sv
// ********************
// Tile memory router
// Decodes commands to off-tile, config or interrupt slice
// and merges the responses in fixed priority
// ********************

`timescale 1ns/1ps
`include "tile_settings.svh"

module tile_mem_router
  (input  logic                           cmd_v_i
  ,input  tile_mem_pkg::mem_opcode_e      cmd_opcode_i
  ,input  logic [`TILE_PADDR_WIDTH-1:0]   cmd_addr_i
  ,input  logic [`TILE_DATA_WIDTH-1:0]    cmd_data_i
  ,output logic                           cmd_ready_o

  ,output logic                           mem_cmd_v_o
  ,output tile_mem_pkg::mem_opcode_e      mem_cmd_opcode_o
  ,output logic [`TILE_PADDR_WIDTH-1:0]   mem_cmd_addr_o
  ,output logic [`TILE_DATA_WIDTH-1:0]    mem_cmd_data_o
  ,input  logic                           mem_cmd_ready_i

  ,input  logic                           mem_resp_v_i
  ,input  tile_mem_pkg::mem_opcode_e      mem_resp_opcode_i
  ,input  logic [`TILE_PADDR_WIDTH-1:0]   mem_resp_addr_i
  ,input  logic [`TILE_DATA_WIDTH-1:0]    mem_resp_data_i
  ,output logic                           mem_resp_yumi_o

  ,output logic                           cfg_cmd_v_o
  ,output tile_mem_pkg::mem_opcode_e      cfg_cmd_opcode_o
  ,output logic [`TILE_PADDR_WIDTH-1:0]   cfg_cmd_addr_o
  ,output logic [`TILE_DATA_WIDTH-1:0]    cfg_cmd_data_o
  ,input  logic                           cfg_cmd_ready_i
  ,input  logic                           cfg_resp_v_i
  ,input  tile_mem_pkg::mem_opcode_e      cfg_resp_opcode_i
  ,input  logic [`TILE_PADDR_WIDTH-1:0]   cfg_resp_addr_i
  ,input  logic [`TILE_DATA_WIDTH-1:0]    cfg_resp_data_i
  ,output logic                           cfg_resp_yumi_o

  ,output logic                           clint_cmd_v_o
  ,output tile_mem_pkg::mem_opcode_e      clint_cmd_opcode_o
  ,output logic [`TILE_PADDR_WIDTH-1:0]   clint_cmd_addr_o
  ,output logic [`TILE_DATA_WIDTH-1:0]    clint_cmd_data_o
  ,input  logic                           clint_cmd_ready_i
  ,input  logic                           clint_resp_v_i
  ,input  tile_mem_pkg::mem_opcode_e      clint_resp_opcode_i
  ,input  logic [`TILE_PADDR_WIDTH-1:0]   clint_resp_addr_i
  ,input  logic [`TILE_DATA_WIDTH-1:0]    clint_resp_data_i
  ,output logic                           clint_resp_yumi_o

  ,output logic                           resp_v_o
  ,output tile_mem_pkg::mem_opcode_e      resp_opcode_o
  ,output logic [`TILE_PADDR_WIDTH-1:0]   resp_addr_o
  ,output logic [`TILE_DATA_WIDTH-1:0]    resp_data_o
  ,input  logic                           resp_yumi_i
  );

  import tile_dev_pkg::*;

  logic    local_cmd;
  dev_id_e dev_sel;

  assign local_cmd = (cmd_addr_i < `TILE_LOCAL_LIMIT);
  assign dev_sel   = dev_id_e'(cmd_addr_i[`TILE_DEV_LSB +: `TILE_DEV_WIDTH]);

  assign cmd_ready_o = mem_cmd_ready_i & cfg_cmd_ready_i & clint_cmd_ready_i;

  // Each valid also waits on the other two readies, so a destination
  // only sees a command in the cycle the upstream transfer happens
  assign mem_cmd_v_o   = cmd_v_i & ~local_cmd & cfg_cmd_ready_i & clint_cmd_ready_i;
  assign cfg_cmd_v_o   = cmd_v_i & local_cmd & (dev_sel == e_dev_cfg)
                         & mem_cmd_ready_i & clint_cmd_ready_i;
  assign clint_cmd_v_o = cmd_v_i & local_cmd & (dev_sel == e_dev_clint)
                         & mem_cmd_ready_i & cfg_cmd_ready_i;

  assign mem_cmd_opcode_o   = cmd_opcode_i;
  assign mem_cmd_addr_o     = cmd_addr_i;
  assign mem_cmd_data_o     = cmd_data_i;
  assign cfg_cmd_opcode_o   = cmd_opcode_i;
  assign cfg_cmd_addr_o     = cmd_addr_i;
  assign cfg_cmd_data_o     = cmd_data_i;
  assign clint_cmd_opcode_o = cmd_opcode_i;
  assign clint_cmd_addr_o   = cmd_addr_i;
  assign clint_cmd_data_o   = cmd_data_i;

  // Off-tile first, then config, then interrupt slice
  assign resp_v_o          = mem_resp_v_i | cfg_resp_v_i | clint_resp_v_i;
  assign mem_resp_yumi_o   = resp_yumi_i & mem_resp_v_i;
  assign cfg_resp_yumi_o   = resp_yumi_i & ~mem_resp_v_i & cfg_resp_v_i;
  assign clint_resp_yumi_o = resp_yumi_i & ~mem_resp_v_i & ~cfg_resp_v_i & clint_resp_v_i;

  always_comb
  begin
    if (mem_resp_v_i)
    begin
      resp_opcode_o = mem_resp_opcode_i;
      resp_addr_o   = mem_resp_addr_i;
      resp_data_o   = mem_resp_data_i;
    end
    else if (cfg_resp_v_i)
    begin
      resp_opcode_o = cfg_resp_opcode_i;
      resp_addr_o   = cfg_resp_addr_i;
      resp_data_o   = cfg_resp_data_i;
    end
    else
    begin
      resp_opcode_o = clint_resp_opcode_i;
      resp_addr_o   = clint_resp_addr_i;
      resp_data_o   = clint_resp_data_i;
    end
  end

endmodule

// File: hw/tile_dev_pkg.sv
// ********************
// Tile local device types
// Device ids and register offsets of the local slices
// ********************

`include "tile_settings.svh"

package tile_dev_pkg;

  // Value of the device field for local traffic
  typedef enum logic [`TILE_DEV_WIDTH-1:0]
  {
    e_dev_clint = `TILE_DEV_WIDTH'(1),
    e_dev_cfg   = `TILE_DEV_WIDTH'(2)
  } dev_id_e;

  // Configuration slice registers
  typedef enum logic [`TILE_REG_WIDTH-1:0]
  {
    e_cfg_freeze   = `TILE_REG_WIDTH'('h00),
    e_cfg_host_did = `TILE_REG_WIDTH'('h08),
    e_cfg_my_did   = `TILE_REG_WIDTH'('h10)
  } cfg_reg_e;

  // Interrupt slice registers
  typedef enum logic [`TILE_REG_WIDTH-1:0]
  {
    e_clint_msip     = `TILE_REG_WIDTH'('h00),
    e_clint_mtimecmp = `TILE_REG_WIDTH'('h08),
    e_clint_mtime    = `TILE_REG_WIDTH'('h10)
  } clint_reg_e;

endpackage

// File: hw/tile_mem_pkg.sv
// ********************
// Tile memory message types
// Opcodes carried on command and response channels
// ********************

package tile_mem_pkg;

  // One bit is enough, only loads and stores reach the tile memory map
  typedef enum logic
  {
    e_mem_load  = 1'b0,
    e_mem_store = 1'b1
  } mem_opcode_e;

endpackage

// File: hw/tile_settings.svh
// ********************
// Tile memory map settings
// Widths, off-tile limit and address field positions
// ********************

`ifndef TILE_SETTINGS_SVH
`define TILE_SETTINGS_SVH

// Physical address and data word
`define TILE_PADDR_WIDTH 40
`define TILE_DATA_WIDTH  64

// Network device id of host and tile
`define TILE_DID_WIDTH   3

// First address that leaves the tile
`define TILE_LOCAL_LIMIT 40'h00_8000_0000

// Local device select field
`define TILE_DEV_LSB     20
`define TILE_DEV_WIDTH   4

// Register offset inside a device, starting at bit 0
`define TILE_REG_WIDTH   8

`endif
